// File: build.f
source/lsb_cfg_pkg.sv
source/lsb_types_pkg.sv
source/store_queue.sv
source/load_path.sv
source/dcache_arbiter.sv
source/ldst_buffer.sv
dv/ldst_buffer_chk.sv
dv/tb_ldst_buffer.sv

// File: dv/ldst_buffer_chk.sv
/*
 * Load/store buffer protocol checks
 * Concurrent assertions on the D-cache port and the flush drain, bound into the top
 */
`timescale 1ns/1ps

module ldst_buffer_chk
  import lsb_types_pkg::*;
(
  input logic    clk_i,
  input logic    rst_ni,
  input logic    flush_i,
  input dc_req_t dc_req_i,
  input dc_rsp_t dc_rsp_i,
  input logic    stq_empty_i,
  input logic    txn_busy_i,
  input logic    drain_i,
  input logic    stall_i
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end
  logic        txn_open_q;    // Request seen on the port, response still due

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      txn_open_q <= 1'b0;
    end else if (dc_req_i.valid) begin
      txn_open_q <= 1'b1;
    end else if (dc_rsp_i.valid) begin
      txn_open_q <= 1'b0;
    end
  end

  // One transaction at a time
  assert property (@(posedge clk_i) disable iff (!rst_ni) txn_open_q |-> !dc_req_i.valid)
    else begin
      $error("D-cache request issued while a transaction was outstanding");
      fail_cnt++;
    end

  // Drain keeps the pipeline stalled while the buffer still has work
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   ((flush_i || drain_i) && (!stq_empty_i || txn_busy_i)) |=> stall_i)
    else begin
      $error("stall_o low while the flush drain was busy");
      fail_cnt++;
    end

  // Stores leave only as a byte, an aligned halfword or an aligned word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (dc_req_i.valid && dc_req_i.is_store) |->
                   ((dc_req_i.size == SZ_BYTE) ||
                    (dc_req_i.size == SZ_HALF && !dc_req_i.addr[0]) ||
                    (dc_req_i.size == SZ_WORD && dc_req_i.addr[1:0] == 2'b00)))
    else begin
      $error("D-cache store with an illegal size or alignment");
      fail_cnt++;
    end

endmodule

bind ldst_buffer ldst_buffer_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .dc_req_i    (dc_req_o),
  .dc_rsp_i    (dc_rsp_i),
  .stq_empty_i (stq_empty),
  .txn_busy_i  (txn_busy),
  .drain_i     (drain_q),
  .stall_i     (stall_o)
);

// File: dv/tb_ldst_buffer.sv
/*
 * Load/store buffer testbench
 * Drives loads, stores and flushes, models a D-cache with random latency
 * and checks every load result against a shadow memory
 */
`timescale 1ns/1ps

module tb_ldst_buffer
  import lsb_cfg_pkg::*;
  import lsb_types_pkg::*;
();

  localparam int TIMEOUT   = 200;
  localparam int MEM_WORDS = 256;

  logic     clk_i, rst_ni, flush_i, stall_o, ld_valid_o;
  lsu_req_t req;
  word_t    ld_data_o;
  dc_req_t  dc_req_o;
  dc_rsp_t  dc_rsp_i;
  word_t    mem    [MEM_WORDS];  // D-cache model contents
  word_t    shadow [MEM_WORDS];  // Program-order view
  int       errors, checks, dc_stores;

  ldst_buffer DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .req_i      (req),
    .stall_o    (stall_o),
    .ld_data_o  (ld_data_o),
    .ld_valid_o (ld_valid_o),
    .dc_req_o   (dc_req_o),
    .dc_rsp_i   (dc_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic word_t init_word(input int unsigned idx);
    return word_t'(idx * 32'h9E37_79B9) ^ 32'hA5C3_0F1E;
  endfunction

  function automatic word_t apply_store(input word_t old, input logic [1:0] off,
                                        input size_e sz, input word_t d);
    word_t w;
    w = old;
    case (sz)
      SZ_BYTE: w[off*8 +: 8] = d[7:0];
      SZ_HALF: w[off[1]*16 +: 16] = d[15:0];
      default: w = d;
    endcase
    return w;
  endfunction

  function automatic word_t ref_load(input addr_t a, input size_e sz, input logic sg);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = shadow[a[9:2]];
    b = w[a[1:0]*8 +: 8];
    h = w[a[1]*16 +: 16];
    case (sz)
      SZ_BYTE: return sg ? {{24{b[7]}}, b} : {24'd0, b};
      SZ_HALF: return sg ? {{16{h[15]}}, h} : {16'd0, h};
      default: return w;
    endcase
  endfunction

  // ======================================================================
  // D-cache model, answers after 1 to 4 cycles
  // ======================================================================
  initial begin : dcache_model
    dc_req_t     r;
    int unsigned lat;
    forever begin
      @(negedge clk_i);
      if (dc_req_o.valid) begin
        r   = dc_req_o;
        lat = 1 + ($urandom % 4);
        repeat (lat) @(posedge clk_i);
        #2;
        if (r.is_store) begin
          mem[r.addr[9:2]] = apply_store(mem[r.addr[9:2]], r.addr[1:0], r.size, r.data);
          dc_stores++;
        end
        dc_rsp_i.valid = 1'b1;
        dc_rsp_i.data  = mem[r.addr[9:2]];
        @(posedge clk_i);
        #2;
        dc_rsp_i = '0;
      end
    end
  end

  // Load result comparison
  always @(negedge clk_i) begin
    if (rst_ni && ld_valid_o) begin
      checks++;
      assert (ld_data_o == ref_load(req.addr, req.size, req.sign)) else begin
        $display("FAILED ld_data_o addr=%h got %h exp %h", req.addr, ld_data_o,
                 ref_load(req.addr, req.size, req.sign));
        errors++;
      end
    end
  end

  task automatic abort_run(input string what);
    $display("ERROR: timeout, %s", what);
    $display("sim failed");
    $finish;
  endtask

  // Present one request and hold it until it is accepted
  task automatic send(input logic st, input addr_t a, input size_e sz, input word_t d,
                      input logic sg, output int stalls);
    logic acc, ldv;
    req.valid    = 1'b1;
    req.is_store = st;
    req.addr     = a;
    req.size     = sz;
    req.data     = d;
    req.sign     = sg;
    stalls       = 0;
    acc          = 1'b0;
    while (!acc) begin
      if (stalls > TIMEOUT) abort_run("request was never accepted");
      @(negedge clk_i);
      acc = !stall_o;
      ldv = ld_valid_o;
      @(posedge clk_i);
      #2;
      if (!acc) stalls++;
    end
    if (st) begin
      shadow[a[9:2]] = apply_store(shadow[a[9:2]], a[1:0], sz, d);
    end else begin
      assert (ldv) else begin
        $display("ERROR: load at %h accepted without ld_valid_o", a);
        errors++;
      end
    end
    req.valid = 1'b0;
  endtask

  task automatic wait_idle();
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      if (n > TIMEOUT) abort_run("store queue did not drain");
      @(negedge clk_i);
      done = DUT.stq_empty && !DUT.txn_busy;
      @(posedge clk_i);
      #2;
      n++;
    end
  endtask

  task automatic fwd_pair(input addr_t sa, input size_e ssz, input addr_t la,
                          input size_e lsz);
    int s;
    send(1'b1, sa, ssz, $urandom, 1'b0, s);
    send(1'b0, la, lsz, '0, 1'b1, s);
    checks++;
    assert (s == 0) else begin
      $display("FAILED stall_o cycles got %h exp %h, load at %h", s, 0, la);
      errors++;
    end
  endtask

  task automatic check_word(input int unsigned idx);
    checks++;
    assert (mem[idx] == shadow[idx]) else begin
      $display("FAILED mem[%h] got %h exp %h", idx, mem[idx], shadow[idx]);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int e0);
    $display("test %0d %s: %0d errors", num, name, errors - e0);
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial begin
    int    s, e0, n0, n;
    logic  done, empty;
    addr_t a;
    size_e sz;
    void'($urandom(28));
    errors    = 0;
    checks    = 0;
    dc_stores = 0;
    rst_ni    = 1'b0;
    flush_i   = 1'b0;
    req       = '0;
    dc_rsp_i  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = init_word(i);
      shadow[i] = mem[i];
    end
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    e0 = errors;  // Words 0xC0 and up are never stored
    for (int k = 0; k < 12; k++) begin
      sz = size_e'(k % 3);
      a  = 32'h300 + ($urandom % 256);
      if (sz == SZ_HALF) a[0] = 1'b0;
      if (sz == SZ_WORD) a[1:0] = 2'b00;
      send(1'b0, a, sz, '0, (k / 3) % 2, s);
    end
    report_test(1, "untouched loads", e0);

    e0 = errors;
    fwd_pair(32'h100, SZ_WORD, 32'h100, SZ_WORD);
    fwd_pair(32'h104, SZ_WORD, 32'h105, SZ_BYTE);
    fwd_pair(32'h10A, SZ_HALF, 32'h10A, SZ_HALF);
    fwd_pair(32'h10E, SZ_HALF, 32'h10F, SZ_BYTE);
    fwd_pair(32'h111, SZ_BYTE, 32'h111, SZ_BYTE);
    fwd_pair(32'h118, SZ_WORD, 32'h11A, SZ_HALF);
    report_test(2, "forwarding", e0);

    e0 = errors;
    wait_idle();
    n0 = dc_stores;
    for (int b = 0; b < 4; b++) send(1'b1, 32'h140 + b, SZ_BYTE, $urandom, 1'b0, s);
    send(1'b0, 32'h140, SZ_WORD, '0, 1'b0, s);
    wait_idle();
    check_word(32'h140 >> 2);
    checks++;
    assert (dc_stores - n0 < 4) else begin
      $display("FAILED dc_req_o store count got %h exp below %h", dc_stores - n0, 4);
      errors++;
    end
    report_test(3, "byte merge", e0);

    e0 = errors;
    send(1'b1, 32'h180, SZ_BYTE, $urandom, 1'b0, s);
    send(1'b0, 32'h180, SZ_WORD, '0, 1'b0, s);
    n = s;
    send(1'b1, 32'h186, SZ_HALF, $urandom, 1'b0, s);
    send(1'b0, 32'h184, SZ_WORD, '0, 1'b0, s);
    checks++;
    assert (n > 0 && s > 0) else begin
      $display("ERROR: partially covered load was not held back");
      errors++;
    end
    report_test(4, "partial overlap", e0);

    e0 = errors;
    n = 0;
    for (int i = 0; i < 2 * STQ_DEPTH + 2; i++) begin
      send(1'b1, 32'h200 + 4 * i, SZ_WORD, $urandom, 1'b0, s);
      n += s;
    end
    checks++;
    assert (n > 0) else begin
      $display("ERROR: store burst never stalled on a full queue");
      errors++;
    end
    for (int i = 0; i < 2 * STQ_DEPTH + 2; i++) send(1'b0, 32'h200 + 4 * i, SZ_WORD, '0, 1'b0, s);
    report_test(5, "store burst", e0);

    e0 = errors;
    for (int i = 0; i < 3; i++) send(1'b1, 32'h280 + 4 * i, SZ_WORD, $urandom, 1'b0, s);
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    n       = 0;
    done    = 1'b0;
    while (!done) begin
      if (n > TIMEOUT) abort_run("flush drain never finished");
      @(negedge clk_i);
      done  = !stall_o;
      empty = DUT.stq_empty && !DUT.txn_busy;
      @(posedge clk_i);
      #2;
      if (!done) n++;
    end
    checks++;
    assert (n > 0 && empty) else begin
      $display("ERROR: flush did not hold stall_o until the queue was empty");
      errors++;
    end
    send(1'b0, 32'h280, SZ_WORD, '0, 1'b0, s);
    send(1'b0, 32'h286, SZ_HALF, '0, 1'b1, s);
    send(1'b0, 32'h289, SZ_BYTE, '0, 1'b1, s);
    report_test(6, "flush drain", e0);

    errors += DUT.u_chk.fail_cnt;  // Concurrent assertion failures
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: source/dcache_arbiter.sv
/*
 * D-cache arbiter
 * Shares the single D-cache port between store drain and load miss,
 * stores first, with one transaction outstanding at most
 */
`timescale 1ns/1ps

module dcache_arbiter
  import lsb_types_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  mem_op_t st_issue_i,
  input  mem_op_t ld_issue_i,
  output logic    st_grant_o,
  output logic    ld_grant_o,
  output dc_req_t dc_req_o,
  input  dc_rsp_t dc_rsp_i,
  output logic    rsp_valid_o,
  output word_t   rsp_data_o,
  output logic    txn_busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    ST_WAIT,
    LD_WAIT
  } arb_state_e;

  arb_state_e state_q, state_d;
  mem_op_t    sel_op;

  always_comb begin
    st_grant_o = 1'b0;
    ld_grant_o = 1'b0;
    state_d    = state_q;
    case (state_q)
      IDLE: begin
        if (st_issue_i.valid) begin
          st_grant_o = 1'b1;
          state_d    = ST_WAIT;
        end else if (ld_issue_i.valid) begin
          ld_grant_o = 1'b1;
          state_d    = LD_WAIT;
        end
      end
      ST_WAIT, LD_WAIT: if (dc_rsp_i.valid) state_d = IDLE;  // Response closes it
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) state_q <= IDLE;
    else         state_q <= state_d;
  end

  assign sel_op = st_grant_o ? st_issue_i : ld_issue_i;

  assign dc_req_o.valid    = st_grant_o || ld_grant_o;  // One-cycle pulse
  assign dc_req_o.is_store = st_grant_o;
  assign dc_req_o.addr     = sel_op.addr;
  assign dc_req_o.size     = sel_op.size;
  assign dc_req_o.data     = sel_op.data;

  // Store acks end here
  assign rsp_valid_o = dc_rsp_i.valid && (state_q == LD_WAIT);
  assign rsp_data_o  = dc_rsp_i.data;
  assign txn_busy_o  = (state_q != IDLE);

endmodule

// File: source/ldst_buffer.sv
/*
 * Load/store buffer top level
 * Holds the flush drain state, combines the stall sources and connects the
 * store queue, the load path and the D-cache arbiter
 */
`timescale 1ns/1ps

module ldst_buffer
  import lsb_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  lsu_req_t req_i,
  output logic     stall_o,
  output word_t    ld_data_o,
  output logic     ld_valid_o,
  output dc_req_t  dc_req_o,
  input  dc_rsp_t  dc_rsp_i
);

  lsu_req_t req_live;
  mem_op_t  st_issue, ld_issue;
  word_t    fwd_data, rsp_data;
  logic     drain_q, st_accept, st_grant, ld_grant, rsp_valid, txn_busy;
  logic     stq_empty, stq_full_block, fwd_hit, ld_wait;

  // ======================================================================
  // Drain mode and stall
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      drain_q <= 1'b0;
    end else if (drain_q) begin
      drain_q <= !(stq_empty && !txn_busy);
    end else if (flush_i && (!stq_empty || txn_busy)) begin
      drain_q <= 1'b1;
    end
  end

  // Requests are hidden from the peers while draining
  always_comb begin
    req_live       = req_i;
    req_live.valid = req_i.valid && !drain_q;
  end

  assign stall_o   = drain_q || stq_full_block || ld_wait;
  assign st_accept = req_live.valid && req_live.is_store && !stall_o;

  store_queue u_store_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .st_accept_i      (st_accept),
    .req_i            (req_live),
    .st_grant_i       (st_grant),
    .st_issue_o       (st_issue),
    .stq_empty_o      (stq_empty),
    .stq_full_block_o (stq_full_block),
    .fwd_hit_o        (fwd_hit),
    .fwd_data_o       (fwd_data)
  );

  load_path u_load_path (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_live),
    .fwd_hit_i   (fwd_hit),
    .fwd_data_i  (fwd_data),
    .stq_empty_i (stq_empty),
    .ld_grant_i  (ld_grant),
    .rsp_valid_i (rsp_valid),
    .rsp_data_i  (rsp_data),
    .ld_issue_o  (ld_issue),
    .ld_wait_o   (ld_wait),
    .ld_data_o   (ld_data_o),
    .ld_valid_o  (ld_valid_o)
  );

  dcache_arbiter u_dcache_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .st_issue_i  (st_issue),
    .ld_issue_i  (ld_issue),
    .st_grant_o  (st_grant),
    .ld_grant_o  (ld_grant),
    .dc_req_o    (dc_req_o),
    .dc_rsp_i    (dc_rsp_i),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data),
    .txn_busy_o  (txn_busy)
  );

endmodule

// File: source/load_path.sv
/*
 * Load path
 * Chooses between a forwarded result and a D-cache miss, holds the miss
 * context until the response and extends the loaded byte or halfword
 */
`timescale 1ns/1ps

module load_path
  import lsb_cfg_pkg::*;
  import lsb_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  lsu_req_t req_i,
  input  logic     fwd_hit_i,
  input  word_t    fwd_data_i,
  input  logic     stq_empty_i,
  input  logic     ld_grant_i,
  input  logic     rsp_valid_i,
  input  word_t    rsp_data_i,
  output mem_op_t  ld_issue_o,
  output logic     ld_wait_o,
  output word_t    ld_data_o,
  output logic     ld_valid_o
);

  logic       is_load;
  logic       pend_q, pend_sign_q, sel_sign;
  size_e      pend_size_q, sel_size;
  logic [1:0] pend_off_q, sel_off;
  word_t      sel_word;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign is_load = req_i.valid && !req_i.is_store;

  // Miss goes out only once older stores have left the queue
  assign ld_issue_o.valid = is_load && !fwd_hit_i && stq_empty_i && !pend_q;
  assign ld_issue_o.addr  = req_i.addr;
  assign ld_issue_o.size  = req_i.size;
  assign ld_issue_o.data  = '0;

  assign ld_wait_o  = is_load && !fwd_hit_i && !rsp_valid_i;
  assign ld_valid_o = is_load && (fwd_hit_i || rsp_valid_i);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (ld_grant_i) begin
      pend_q <= 1'b1;
    end else if (rsp_valid_i) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_grant_i) begin
      pend_size_q <= req_i.size;
      pend_off_q  <= req_i.addr[1:0];
      pend_sign_q <= req_i.sign;
    end
  end

  assign sel_word = fwd_hit_i ? fwd_data_i      : rsp_data_i;
  assign sel_off  = fwd_hit_i ? req_i.addr[1:0] : pend_off_q;
  assign sel_size = fwd_hit_i ? req_i.size      : pend_size_q;
  assign sel_sign = fwd_hit_i ? req_i.sign      : pend_sign_q;

  assign byte_sel = sel_word[{sel_off, 3'b000} +: 8];
  assign half_sel = sel_word[{sel_off[1], 4'b0000} +: 16];

  always_comb begin
    case (sel_size)
      SZ_BYTE: ld_data_o = {{(XLEN-8){sel_sign & byte_sel[7]}}, byte_sel};
      SZ_HALF: ld_data_o = {{(XLEN-16){sel_sign & half_sel[15]}}, half_sel};
      SZ_WORD: ld_data_o = sel_word;
      default: ld_data_o = '0;
    endcase
  end

endmodule

// File: source/lsb_cfg_pkg.sv
/*
 * Load/store buffer configuration
 * Data path widths, store queue depth and the pointer and count widths
 * derived from that depth
 */

package lsb_cfg_pkg;

  localparam int unsigned XLEN      = 32;
  localparam int unsigned STRB_W    = XLEN / 8;  // One strobe per byte lane
  localparam int unsigned STQ_DEPTH = 4;

  // Derived widths, depth must stay a power of two for pointer wrap
  localparam int unsigned STQ_PTR_W = $clog2(STQ_DEPTH);
  localparam int unsigned STQ_CNT_W = $clog2(STQ_DEPTH + 1);

endpackage

// File: source/lsb_types_pkg.sv
/*
 * Load/store buffer types
 * Vector typedefs, the access size encoding and the request and response
 * structs used on the pipeline, peer and D-cache sides
 */

package lsb_types_pkg;

  import lsb_cfg_pkg::*;

  typedef logic [XLEN-1:0]   addr_t;
  typedef logic [XLEN-1:0]   word_t;
  typedef logic [STRB_W-1:0] strb_t;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2,
    SZ_NONE = 2'd3
  } size_e;

  // Pipeline request, store data sits in the low bits
  typedef struct packed {
    logic  valid;
    logic  is_store;
    addr_t addr;
    size_e size;
    word_t data;
    logic  sign;
  } lsu_req_t;

  typedef struct packed {
    logic  valid;
    logic  is_store;
    addr_t addr;
    size_e size;
    word_t data;
  } dc_req_t;

  // Load response carries the whole word
  typedef struct packed {
    logic  valid;
    word_t data;
  } dc_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    size_e size;
    word_t data;
  } mem_op_t;

endpackage

// File: source/store_queue.sv
/*
 * Store queue
 * Circular buffer of word address, byte strobes and data with merging into
 * the youngest entry, store-to-load forwarding and head issue formatting
 */
`timescale 1ns/1ps

module store_queue
  import lsb_cfg_pkg::*;
  import lsb_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     st_accept_i,
  input  lsu_req_t req_i,
  input  logic     st_grant_i,
  output mem_op_t  st_issue_o,
  output logic     stq_empty_o,
  output logic     stq_full_block_o,
  output logic     fwd_hit_o,
  output word_t    fwd_data_o
);

  function automatic strb_t size_to_strb(input logic [1:0] off, input size_e size);
    strb_t strb;
    strb = '0;
    case (size)
      SZ_BYTE: strb = strb_t'(1) << off;
      SZ_HALF: strb = off[1] ? 4'b1100 : 4'b0011;
      SZ_WORD: strb = '1;
      default: strb = '0;
    endcase
    return strb;
  endfunction

  // Only single bytes, aligned halfwords and full words can be issued
  function automatic logic strb_ok(input strb_t strb);
    case (strb)
      4'b0001, 4'b0010, 4'b0100, 4'b1000,
      4'b0011, 4'b1100, 4'b1111: return 1'b1;
      default:                   return 1'b0;
    endcase
  endfunction

  logic [XLEN-1:2]      wa_q   [STQ_DEPTH];
  strb_t                strb_q [STQ_DEPTH];
  word_t                data_q [STQ_DEPTH];
  logic [STQ_PTR_W-1:0] head_q, tail_q, tail_prev, scan_ptr;
  logic [STQ_CNT_W-1:0] cnt_q;

  logic   full, tail_hit, merge, push;
  strb_t  req_strb, merged_strb, need;
  word_t  req_lanes, merged_data;
  logic   [1:0] issue_off;
  size_e  issue_size;

  assign stq_empty_o = (cnt_q == '0);
  assign full        = (cnt_q == STQ_CNT_W'(STQ_DEPTH));
  assign tail_prev   = tail_q - 1'b1;
  assign req_strb    = size_to_strb(req_i.addr[1:0], req_i.size);

  // Replicate the store data into every lane, the strobe picks the right one
  always_comb begin
    case (req_i.size)
      SZ_BYTE: req_lanes = {4{req_i.data[7:0]}};
      SZ_HALF: req_lanes = {2{req_i.data[15:0]}};
      default: req_lanes = req_i.data;
    endcase
  end

  // ======================================================================
  // Tail merge
  // ======================================================================
  assign merged_strb = strb_q[tail_prev] | req_strb;

  always_comb begin
    merged_data = data_q[tail_prev];
    for (int b = 0; b < STRB_W; b++) begin
      if (req_strb[b]) merged_data[b*8 +: 8] = req_lanes[b*8 +: 8];
    end
  end

  // A lone entry that is leaving this cycle cannot take more bytes
  assign tail_hit = req_i.valid && req_i.is_store && !stq_empty_o &&
                    (wa_q[tail_prev] == req_i.addr[XLEN-1:2]) && strb_ok(merged_strb) &&
                    !(st_grant_i && (cnt_q == STQ_CNT_W'(1)));

  assign merge            = st_accept_i && tail_hit;
  assign push             = st_accept_i && !tail_hit;
  assign stq_full_block_o = req_i.valid && req_i.is_store && full && !tail_hit;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push)       tail_q <= tail_q + 1'b1;
      if (st_grant_i) head_q <= head_q + 1'b1;
      cnt_q <= cnt_q + STQ_CNT_W'(push) - STQ_CNT_W'(st_grant_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      wa_q[tail_q]   <= req_i.addr[XLEN-1:2];
      strb_q[tail_q] <= req_strb;
      data_q[tail_q] <= req_lanes;
    end else if (merge) begin
      strb_q[tail_prev] <= merged_strb;
      data_q[tail_prev] <= merged_data;
    end
  end

  // ======================================================================
  // Forwarding scan, youngest entry first
  // ======================================================================
  always_comb begin
    fwd_data_o = '0;
    need       = req_strb;
    scan_ptr   = tail_prev;
    for (int k = 0; k < STQ_DEPTH; k++) begin
      if ((k < cnt_q) && (wa_q[scan_ptr] == req_i.addr[XLEN-1:2])) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (need[b] && strb_q[scan_ptr][b]) begin
            fwd_data_o[b*8 +: 8] = data_q[scan_ptr][b*8 +: 8];
            need[b]              = 1'b0;
          end
        end
      end
      scan_ptr = scan_ptr - 1'b1;
    end
  end

  assign fwd_hit_o = req_i.valid && !req_i.is_store && (req_strb != '0) && (need == '0);

  // Head entry back to address, size and low-aligned data
  always_comb begin
    case (strb_q[head_q])
      4'b0001, 4'b0010, 4'b0100, 4'b1000: issue_size = SZ_BYTE;
      4'b0011, 4'b1100:                   issue_size = SZ_HALF;
      4'b1111:                            issue_size = SZ_WORD;
      default:                            issue_size = SZ_NONE;
    endcase
    case (strb_q[head_q])
      4'b0010:          issue_off = 2'd1;
      4'b0100, 4'b1100: issue_off = 2'd2;
      4'b1000:          issue_off = 2'd3;
      default:          issue_off = 2'd0;
    endcase
  end

  assign st_issue_o.valid = !stq_empty_o;
  assign st_issue_o.addr  = {wa_q[head_q], issue_off};
  assign st_issue_o.size  = issue_size;
  assign st_issue_o.data  = data_q[head_q] >> {issue_off, 3'b000};

endmodule
